// File: compile.f
hdl/dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_dispatch.sv
hdl/acc_lane.sv
hdl/rsp_collect.sv
hdl/acc_top.sv
sim/acc_top_tb.sv

// File: hdl/acc_lane.sv
`timescale 1ns/1ps
`default_nettype none

module acc_lane (
	input logic clk,
	input logic rst_n,
	input dbg_pkg::cmd_word_u cmd_word,
	input logic cmd_valid,
	output logic cmd_credit,
	output logic rsp_valid,
	output logic [dbg_pkg::ACC_W-1:0] rsp_data,
	input logic rsp_credit,
	output logic [dbg_pkg::ACC_W-1:0] acc
);

	// small command queue
	dbg_pkg::cmd_word_u q_mem [dbg_pkg::QUEUE_DEPTH];
	logic [dbg_pkg::PTR_W-1:0] wr_ptr;
	logic [dbg_pkg::PTR_W-1:0] rd_ptr;
	logic [dbg_pkg::CRED_W-1:0] q_cnt;
	dbg_pkg::cmd_word_u head;
	// one response slot downstream
	logic rsp_cred;
	logic head_read;
	logic pop;
	logic pop_read;

	assign head = q_mem[rd_ptr];
	assign head_read = head.arith_s.op == dbg_pkg::OP_READ;
	// a READ stalls until the collector has room
	assign pop = (q_cnt != '0) && (!head_read || rsp_cred);
	assign pop_read = pop && head_read;
	// each pop frees a dispatcher credit
	assign cmd_credit = pop;

	always_ff @(posedge clk) begin
		if (cmd_valid)
			q_mem[wr_ptr] <= cmd_word;
		// value before any update, READ leaves acc alone
		if (pop_read)
			rsp_data <= acc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
		end else begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({cmd_valid, pop})
				2'b10: q_cnt <= q_cnt + 1'b1;
				2'b01: q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			rsp_cred <= 1'b1;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= pop_read;
			// credit comes back once the slot has drained
			rsp_cred <= (rsp_cred & ~pop_read) | rsp_credit;
			if (pop) begin
				case (head.arith_s.op)
					dbg_pkg::OP_LOAD: acc <= head.arith_s.operand;
					dbg_pkg::OP_ADD: acc <= acc + head.arith_s.operand;
					dbg_pkg::OP_XOR: acc <= acc ^ head.arith_s.operand;
					dbg_pkg::OP_SHIFT: begin
						// logical, zero fill either way
						if (head.shift_s.dir)
							acc <= acc >> head.shift_s.amount;
						else
							acc <= acc << head.shift_s.amount;
					end
					default: acc <= acc;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/acc_top.sv
`timescale 1ns/1ps
`default_nettype none

module acc_top (
	input logic clk,
	input logic rst_n,
	input logic rx,
	output logic tx,
	output logic [7:0] led
);

	// receiver to dispatcher
	logic [7:0] rx_data;
	logic rx_valid;
	// dispatcher to lanes
	dbg_pkg::cmd_word_u cmd_word;
	logic [dbg_pkg::NUM_LANES-1:0] cmd_valid;
	logic [dbg_pkg::NUM_LANES-1:0] cmd_credit;
	// lanes to collector
	logic [dbg_pkg::NUM_LANES-1:0] rsp_valid;
	logic [dbg_pkg::NUM_LANES*dbg_pkg::ACC_W-1:0] rsp_data;
	logic [dbg_pkg::NUM_LANES-1:0] rsp_credit;
	logic [dbg_pkg::ACC_W-1:0] lane_acc [dbg_pkg::NUM_LANES];
	// collector to transmitter
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_busy;

	// lane 0 shows on the board
	assign led = lane_acc[0][7:0];

	uart_rx u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	cmd_dispatch u_disp (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.cmd_word(cmd_word),
		.cmd_valid(cmd_valid),
		.cmd_credit(cmd_credit)
	);

	genvar i;
	generate
		for (i = 0; i < dbg_pkg::NUM_LANES; i++) begin : g_lane
			acc_lane u_lane (
				.clk(clk),
				.rst_n(rst_n),
				.cmd_word(cmd_word),
				.cmd_valid(cmd_valid[i]),
				.cmd_credit(cmd_credit[i]),
				.rsp_valid(rsp_valid[i]),
				.rsp_data(rsp_data[i*dbg_pkg::ACC_W +: dbg_pkg::ACC_W]),
				.rsp_credit(rsp_credit[i]),
				.acc(lane_acc[i])
			);
		end
	endgenerate

	rsp_collect u_coll (
		.clk(clk),
		.rst_n(rst_n),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_credit(rsp_credit),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.tx_busy(tx_busy)
	);

	uart_tx u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.tx_data(tx_data),
		.tx_start(tx_start),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

// File: hdl/cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
	input logic clk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output dbg_pkg::cmd_word_u cmd_word,
	output logic [dbg_pkg::NUM_LANES-1:0] cmd_valid,
	input logic [dbg_pkg::NUM_LANES-1:0] cmd_credit
);

	// byte assembly
	logic [1:0] byte_cnt;
	dbg_pkg::cmd_word_u word_q;
	// full word waiting for issue
	logic pending;
	// one credit counter per lane
	logic [dbg_pkg::CRED_W-1:0] credit_cnt [dbg_pkg::NUM_LANES];
	// decode of the held word
	logic [dbg_pkg::LANE_W-1:0] tgt;
	logic [3:0] op;
	logic op_ok;
	logic has_credit;
	logic take_byte;

	// bytes during a stall are lost
	assign take_byte = rx_valid && !pending;

	assign op = word_q.arith_s.op;
	assign tgt = word_q.arith_s.lane;
	assign op_ok = (op == dbg_pkg::OP_LOAD) || (op == dbg_pkg::OP_ADD) ||
		(op == dbg_pkg::OP_XOR) || (op == dbg_pkg::OP_SHIFT) ||
		(op == dbg_pkg::OP_READ);
	assign has_credit = credit_cnt[tgt] != '0;

	assign cmd_word = word_q;

	// issue straight from the held word
	always_comb begin
		cmd_valid = '0;
		if (pending && op_ok && has_credit)
			cmd_valid[tgt] = 1'b1;
	end

	// lsb first, so each byte goes in at the top
	always_ff @(posedge clk) begin
		if (take_byte)
			word_q <= {rx_data, word_q[31:8]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= 2'd0;
			pending <= 1'b0;
		end else begin
			if (take_byte) begin
				byte_cnt <= byte_cnt + 1'b1;
				// fourth byte completes the word
				if (byte_cnt == 2'd3)
					pending <= 1'b1;
			end else if (pending && (!op_ok || has_credit)) begin
				// issued, or dropped as a bad opcode
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dbg_pkg::NUM_LANES; i++)
				credit_cnt[i] <= dbg_pkg::CRED_INIT;
		end else begin
			for (int i = 0; i < dbg_pkg::NUM_LANES; i++) begin
				// issue and return together cancel out
				case ({cmd_valid[i], cmd_credit[i]})
					2'b10: credit_cnt[i] <= credit_cnt[i] - 1'b1;
					2'b01: credit_cnt[i] <= credit_cnt[i] + 1'b1;
					default: credit_cnt[i] <= credit_cnt[i];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	// uart bit timing
	localparam int CLKS_PER_BIT = 16;
	localparam int TICK_W = $clog2(CLKS_PER_BIT);
	// reload values for the bit timers, counted down to zero
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(CLKS_PER_BIT - 1);
	localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(CLKS_PER_BIT / 2 - 1);

	// lane bank geometry
	localparam int NUM_LANES = 4;
	localparam int LANE_W = 2;
	localparam int ACC_W = 16;

	// per-lane command queue, also the dispatcher credit budget
	localparam int QUEUE_DEPTH = 2;
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [CRED_W-1:0] CRED_INIT = CRED_W'(QUEUE_DEPTH);

	// opcodes, anything above OP_READ is dropped
	localparam logic [3:0] OP_LOAD = 4'd0;
	localparam logic [3:0] OP_ADD = 4'd1;
	localparam logic [3:0] OP_XOR = 4'd2;
	localparam logic [3:0] OP_SHIFT = 4'd3;
	localparam logic [3:0] OP_READ = 4'd4;

	// one 32-bit command, two views of the low 26 bits
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [LANE_W-1:0] lane;
			logic [9:0] rsvd;
			logic [ACC_W-1:0] operand;
		} arith_s;
		struct packed {
			logic [3:0] op;
			logic [LANE_W-1:0] lane;
			// 0 shifts left
			logic dir;
			logic [3:0] amount;
			logic [20:0] rsvd;
		} shift_s;
	} cmd_word_u;

endpackage

`default_nettype wire

// File: hdl/rsp_collect.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_collect (
	input logic clk,
	input logic rst_n,
	input logic [dbg_pkg::NUM_LANES-1:0] rsp_valid,
	input logic [dbg_pkg::NUM_LANES*dbg_pkg::ACC_W-1:0] rsp_data,
	output logic [dbg_pkg::NUM_LANES-1:0] rsp_credit,
	output logic [7:0] tx_data,
	output logic tx_start,
	input logic tx_busy
);

	// one response slot per lane
	logic [dbg_pkg::NUM_LANES-1:0] slot_full;
	logic [dbg_pkg::ACC_W-1:0] slot_data [dbg_pkg::NUM_LANES];
	// round robin state
	logic [dbg_pkg::LANE_W-1:0] rr_ptr;
	logic [dbg_pkg::LANE_W-1:0] pick;
	logic pick_ok;
	// granted slot
	logic active;
	logic [dbg_pkg::LANE_W-1:0] cur;
	logic hi_phase;
	logic send_go;

	// tx_start still high means busy has not risen yet
	assign send_go = active && !tx_busy && !tx_start;

	// first full slot at or after the pointer
	always_comb begin
		logic [dbg_pkg::LANE_W-1:0] idx;
		pick = rr_ptr;
		pick_ok = 1'b0;
		idx = rr_ptr;
		for (int k = dbg_pkg::NUM_LANES - 1; k >= 0; k--) begin
			idx = rr_ptr + k[dbg_pkg::LANE_W-1:0];
			if (slot_full[idx]) begin
				pick = idx;
				pick_ok = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < dbg_pkg::NUM_LANES; i++) begin
			if (rsp_valid[i])
				slot_data[i] <= rsp_data[i*dbg_pkg::ACC_W +: dbg_pkg::ACC_W];
		end
		// low byte first
		if (send_go)
			tx_data <= hi_phase ? slot_data[cur][15:8] : slot_data[cur][7:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_full <= '0;
			rr_ptr <= '0;
			active <= 1'b0;
			cur <= '0;
			hi_phase <= 1'b0;
			tx_start <= 1'b0;
			rsp_credit <= '0;
		end else begin
			tx_start <= 1'b0;
			rsp_credit <= '0;
			// a lane only sends when its slot is free
			for (int i = 0; i < dbg_pkg::NUM_LANES; i++) begin
				if (rsp_valid[i])
					slot_full[i] <= 1'b1;
			end
			if (!active) begin
				if (pick_ok) begin
					active <= 1'b1;
					cur <= pick;
					hi_phase <= 1'b0;
				end
			end else if (send_go) begin
				tx_start <= 1'b1;
				if (!hi_phase) begin
					hi_phase <= 1'b1;
				end else begin
					// high byte starting, slot is done
					slot_full[cur] <= 1'b0;
					rsp_credit[cur] <= 1'b1;
					active <= 1'b0;
					rr_ptr <= cur + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input logic clk,
	input logic rst_n,
	input logic rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);

	// two-flop synchronizer on the line
	logic rx_meta;
	logic rx_sync;
	// frame tracking
	logic active;
	logic [3:0] bit_idx;
	logic [dbg_pkg::TICK_W-1:0] tick_cnt;
	logic [7:0] shift;
	logic sample;

	// timer hits zero in the middle of a bit
	assign sample = active && (tick_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			bit_idx <= 4'd0;
			tick_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!active) begin
				// falling edge on an idle line, go look at mid start bit
				if (!rx_sync) begin
					active <= 1'b1;
					bit_idx <= 4'd0;
					tick_cnt <= dbg_pkg::TICK_HALF;
				end
			end else if (tick_cnt != '0) begin
				tick_cnt <= tick_cnt - 1'b1;
			end else begin
				tick_cnt <= dbg_pkg::TICK_LAST;
				if (bit_idx == 4'd0 && rx_sync) begin
					// glitch, not a real start bit
					active <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					// stop bit must be high
					active <= 1'b0;
					rx_valid <= rx_sync;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9)
			shift <= {rx_sync, shift[7:1]};
		if (sample && bit_idx == 4'd9 && rx_sync)
			rx_data <= shift;
	end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input logic clk,
	input logic rst_n,
	input logic [7:0] tx_data,
	input logic tx_start,
	output logic tx,
	output logic tx_busy
);

	// stop, data, start, shifted out from bit 0
	logic [9:0] frame;
	logic [3:0] bit_idx;
	logic [dbg_pkg::TICK_W-1:0] tick_cnt;

	// all ones when idle keeps the line high
	assign tx = frame[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame <= '1;
			bit_idx <= 4'd0;
			tick_cnt <= '0;
			tx_busy <= 1'b0;
		end else begin
			if (!tx_busy) begin
				if (tx_start) begin
					frame <= {1'b1, tx_data, 1'b0};
					bit_idx <= 4'd0;
					tick_cnt <= dbg_pkg::TICK_LAST;
					tx_busy <= 1'b1;
				end
			end else if (tick_cnt != '0) begin
				tick_cnt <= tick_cnt - 1'b1;
			end else begin
				// next bit, ones fill in behind
				frame <= {1'b1, frame[9:1]};
				tick_cnt <= dbg_pkg::TICK_LAST;
				if (bit_idx == 4'd9)
					tx_busy <= 1'b0;
				else
					bit_idx <= bit_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the accumulator bank testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module acc_top_tb \
	-f compile.f \
	-o acc_top_tb_sim

out=$(./obj_dir/acc_top_tb_sim)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: sim/acc_stim.txt
# columns: command word, response expected (0/1), expected response, expected led
# words go out lsb byte first, led is the low byte of lane 0
00001234 0 0000 34
40000000 1 1234 34
1000ff00 0 0000 34
40000000 1 1134 34
200000ff 0 0000 cb
40000000 1 11cb cb
080000f0 0 0000 cb
38800000 0 0000 cb
48000000 1 0f00 cb
3b200000 0 0000 cb
48000000 1 0007 cb
5000beef 0 0000 cb
f0001111 0 0000 cb
0400fff0 0 0000 cb
14000025 0 0000 cb
44000000 1 0015 cb
40000000 1 11cb cb
31000000 0 0000 00
40000000 1 cb00 00

// File: sim/acc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module acc_top_tb;

	// uart bit time seen from the host side
	localparam int BIT_CLKS = 16;
	// budget per stim line and extra room for reset and drain in bit times
	localparam int LINE_BITS = 80;
	localparam int MARGIN_BITS = 60;
	// longest wait for one response in bit times
	localparam int RSP_WAIT_BITS = 40;

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;
	logic [7:0] led;

	// stim table with one entry per line
	logic [31:0] stim_word [$];
	logic stim_rsp [$];
	logic [15:0] stim_val [$];
	logic [7:0] stim_led [$];
	// responses decoded off tx with the low byte first
	logic [15:0] got_rsp [$];

	int mismatch_cnt;
	int missing_cnt;
	int extra_cnt;
	longint cycle_cnt = 0;
	// zero until the stim table is loaded
	longint cycle_limit = 0;

	acc_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.tx(tx),
		.led(led)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
			mismatch_cnt++;
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d mismatches, %0d missing responses, %0d extra responses",
			mismatch_cnt, missing_cnt, extra_cnt);
	endtask

	task automatic load_stim();
		int fd;
		int n;
		int flag;
		logic [31:0] w;
		logic [15:0] r;
		logic [7:0] l;
		string line;
		fd = $fopen("sim/acc_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/acc_stim.txt");
			missing_cnt++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				// header and blank lines
				if (n == 0 || line.len() < 8 || line[0] == "#")
					continue;
				n = $sscanf(line, "%h %d %h %h", w, flag, r, l);
				if (n == 4) begin
					stim_word.push_back(w);
					stim_rsp.push_back(flag != 0);
					stim_val.push_back(r);
					stim_led.push_back(l);
				end
			end
			$fclose(fd);
		end
	endtask

	// one bit on rx starting at the next falling edge
	task automatic drive_bit(input logic b);
		@(negedge clk);
		rx = b;
		repeat (BIT_CLKS - 1) @(negedge clk);
	endtask

	task automatic send_byte(input logic [7:0] data);
		drive_bit(1'b0);
		for (int b = 0; b < 8; b++)
			drive_bit(data[b]);
		drive_bit(1'b1);
	endtask

	// lsb byte first
	task automatic send_word(input logic [31:0] w);
		for (int k = 0; k < 4; k++)
			send_byte(w[8*k +: 8]);
	endtask

	task automatic recv_byte(output logic [7:0] data);
		@(negedge clk);
		while (tx !== 1'b0)
			@(negedge clk);
		// to the middle of the start bit
		repeat (BIT_CLKS / 2) @(negedge clk);
		check_val("tx start bit", {15'd0, tx}, 16'd0);
		for (int b = 0; b < 8; b++) begin
			repeat (BIT_CLKS) @(negedge clk);
			data[b] = tx;
		end
		repeat (BIT_CLKS) @(negedge clk);
		check_val("tx stop bit", {15'd0, tx}, 16'd1);
	endtask

	task automatic wait_rsp(output logic ok);
		int n;
		n = 0;
		while (got_rsp.size() == 0 && n < RSP_WAIT_BITS * BIT_CLKS) begin
			@(negedge clk);
			n++;
		end
		ok = got_rsp.size() != 0;
	endtask

	// anything still queued came without a READ
	task automatic count_extra(input int line_idx);
		while (got_rsp.size() != 0) begin
			$display("unexpected response %h after stim line %0d",
				got_rsp.pop_front(), line_idx);
			extra_cnt++;
		end
	endtask

	// tx monitor pairs bytes into responses
	initial begin : tx_monitor
		logic [7:0] lo_byte;
		logic [7:0] cur_byte;
		logic have_lo;
		have_lo = 1'b0;
		lo_byte = 8'd0;
		forever begin
			recv_byte(cur_byte);
			if (!have_lo) begin
				lo_byte = cur_byte;
				have_lo = 1'b1;
			end else begin
				got_rsp.push_back({cur_byte, lo_byte});
				have_lo = 1'b0;
			end
		end
	end

	// cycle limit watchdog
	initial begin : watchdog
		while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		report_counts();
		$display("Test failed");
		$finish;
	end

	initial begin : main_seq
		int gap;
		logic ok;
		mismatch_cnt = 0;
		missing_cnt = 0;
		extra_cnt = 0;
		rx = 1'b1;
		rst_n = 1'b0;
		void'($urandom(32'hbf98_cd03));
		load_stim();
		if (stim_word.size() == 0) begin
			$display("no stimulus lines were read");
			missing_cnt++;
		end
		cycle_limit = longint'(stim_word.size() * LINE_BITS + MARGIN_BITS) * BIT_CLKS;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle line before the first frame
		repeat (BIT_CLKS) @(negedge clk);
		for (int i = 0; i < stim_word.size(); i++) begin
			send_word(stim_word[i]);
			// rest of the stop bit plus 4 cycles
			repeat (5) @(negedge clk);
			check_val("led", {8'd0, led}, {8'd0, stim_led[i]});
			if (stim_rsp[i]) begin
				wait_rsp(ok);
				if (!ok) begin
					$display("no response for stim line %0d", i);
					missing_cnt++;
				end else begin
					check_val("tx response", got_rsp.pop_front(), stim_val[i]);
				end
			end
			gap = int'($urandom % 4);
			repeat ((12 + gap) * BIT_CLKS) @(negedge clk);
			count_extra(i);
		end
		// a late response from the last line needs a full frame pair to show up
		repeat (RSP_WAIT_BITS * BIT_CLKS) @(negedge clk);
		count_extra(stim_word.size() - 1);
		report_counts();
		if (mismatch_cnt == 0 && missing_cnt == 0 && extra_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
